/* hdl/tlb_pkg.sv */
package tlb_pkg;

    localparam int tlb_num = 32;
    localparam int cmd_depth = 2;
    localparam int cmd_ptr_w = $clog2(cmd_depth);

    typedef logic [4:0]   tlb_idx_t;
    typedef logic [18:0]  vppn_t;
    typedef logic [9:0]   asid_t;
    typedef logic [19:0]  ppn_t;
    typedef logic [5:0]   ps_t;
    typedef logic [1:0]   mat_t;
    typedef logic [1:0]   plv_t;
    // Virtual address bits 21 down to 12.
    typedef logic [21:12] va_bits_t;

    localparam ps_t ps_4k = 6'd12;
    localparam ps_t ps_4m = 6'd21;

    typedef struct packed {
        ppn_t ppn;
        logic v;
        logic d;
        mat_t mat;
        plv_t plv;
    } page_attr_t;

    // P0 maps the even page and p1 the odd page.
    typedef struct packed {
        logic       e;
        logic       g;
        ps_t        ps;
        asid_t      asid;
        vppn_t      vppn;
        page_attr_t p0;
        page_attr_t p1;
    } tlb_entry_t;

    typedef logic [2:0] tlb_op_t;

    localparam tlb_op_t op_srch     = 3'd0;
    localparam tlb_op_t op_rd       = 3'd1;
    localparam tlb_op_t op_wr       = 3'd2;
    localparam tlb_op_t op_fill     = 3'd3;
    localparam tlb_op_t op_inv_all  = 3'd4;
    localparam tlb_op_t op_inv_asid = 3'd5;
    localparam tlb_op_t op_inv_va   = 3'd6;

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_sweep,
        st_resp
    } ctrl_state_t;

    // Full forces a 19-bit compare whatever the page size.
    function automatic logic entry_hit(tlb_entry_t ent, asid_t asid, vppn_t vppn, logic full);
        logic asid_ok;
        logic vppn_ok;
        asid_ok = ent.g || (ent.asid == asid);
        if (full || ent.ps == ps_4k) begin
            vppn_ok = (ent.vppn == vppn);
        end else begin
            vppn_ok = (ent.vppn[18:8] == vppn[18:8]);
        end
        return ent.e && asid_ok && vppn_ok;
    endfunction

endpackage

/* hdl/tlb_entry_if.sv */
interface tlb_entry_if import tlb_pkg::*; ();

    logic       we;
    tlb_idx_t   w_index;
    tlb_entry_t w_entry;
    tlb_idx_t   r_index;
    tlb_entry_t r_entry;
    // Clears only the e bit of one entry.
    logic       clr;
    tlb_idx_t   clr_index;

    modport ctrl (
        output we, w_index, w_entry, r_index, clr, clr_index,
        input  r_entry
    );

    modport array (
        input  we, w_index, w_entry, r_index, clr, clr_index,
        output r_entry
    );

    modport view (
        input r_entry
    );

endinterface

/* hdl/tlb_entry_array.sv */
module tlb_entry_array import tlb_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    tlb_entry_if.array entry_if,
    output tlb_entry_t all_entries [tlb_num]
);

    tlb_entry_t         data_q [tlb_num];
    logic [tlb_num-1:0] e_q;

    // Valid bits.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_q <= '0;
        end else begin
            if (entry_if.we) begin
                e_q[entry_if.w_index] <= entry_if.w_entry.e;
            end
            if (entry_if.clr) begin
                e_q[entry_if.clr_index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (entry_if.we) begin
            data_q[entry_if.w_index] <= entry_if.w_entry;
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            all_entries[i]   = data_q[i];
            all_entries[i].e = e_q[i];
        end
    end

    assign entry_if.r_entry = all_entries[entry_if.r_index];

endmodule

/* hdl/tlb_match.sv */
module tlb_match import tlb_pkg::*; (
    input  tlb_entry_t         all_entries [tlb_num],
    input  vppn_t              s0_vppn,
    input  asid_t              s0_asid,
    input  vppn_t              s1_vppn,
    input  asid_t              s1_asid,
    input  vppn_t              s_vppn,
    input  asid_t              s_asid,
    output logic [tlb_num-1:0] found0,
    output logic [tlb_num-1:0] found1,
    output logic               s_hit,
    output tlb_idx_t           s_index
);

    logic [tlb_num-1:0] found_s;

    for (genvar i = 0; i < tlb_num; i++) begin : g_cmp
        assign found0[i]  = entry_hit(all_entries[i], s0_asid, s0_vppn, 1'b0);
        assign found1[i]  = entry_hit(all_entries[i], s1_asid, s1_vppn, 1'b0);
        // Search always compares the whole page-pair number.
        assign found_s[i] = entry_hit(all_entries[i], s_asid, s_vppn, 1'b1);
    end

    assign s_hit = |found_s;

    // One-hot to binary, 0 on a miss.
    always_comb begin
        s_index = '0;
        for (int i = 0; i < tlb_num; i++) begin
            if (found_s[i]) begin
                s_index = s_index | tlb_idx_t'(i);
            end
        end
    end

endmodule

/* hdl/tlb_translate.sv */
module tlb_translate import tlb_pkg::*; (
    input  tlb_entry_t         all_entries [tlb_num],
    input  logic [tlb_num-1:0] found,
    input  va_bits_t           va_bits,
    output ppn_t               pa_ppn,
    output logic               pa_v,
    output logic               pa_d,
    output mat_t               pa_mat,
    output plv_t               pa_plv,
    output logic               miss
);

    tlb_entry_t sel;
    page_attr_t page;
    logic       is_4k;
    logic       odd;

    // Found is one-hot, so OR-ing the hitting entries selects the one.
    always_comb begin
        sel = '0;
        for (int i = 0; i < tlb_num; i++) begin
            if (found[i]) begin
                sel = tlb_entry_t'(sel | all_entries[i]);
            end
        end
    end

    assign is_4k = (sel.ps == ps_4k);
    assign odd   = is_4k ? va_bits[12] : va_bits[21];
    assign page  = odd ? sel.p1 : sel.p0;

    // Large pages keep the upper 11 ppn bits.
    assign pa_ppn = is_4k ? page.ppn : {page.ppn[19:9], va_bits[20:12]};
    assign pa_v   = page.v;
    assign pa_d   = page.d;
    assign pa_mat = page.mat;
    assign pa_plv = page.plv;
    assign miss   = ~|found;

endmodule

/* hdl/tlb_index_counter.sv */
module tlb_index_counter import tlb_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fill_step,
    input  logic     sweep_start,
    input  logic     sweep_step,
    output tlb_idx_t fill_index,
    output tlb_idx_t sweep_index,
    output logic     sweep_last
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_index  <= '0;
            sweep_index <= '0;
        end else begin
            // Wraps at 32 by the index width.
            if (fill_step) begin
                fill_index <= fill_index + 1'b1;
            end
            if (sweep_start) begin
                sweep_index <= '0;
            end else if (sweep_step) begin
                sweep_index <= sweep_index + 1'b1;
            end
        end
    end

    assign sweep_last = (sweep_index == tlb_idx_t'(tlb_num - 1));

endmodule

/* hdl/tlb_cmd_ctrl.sv */
module tlb_cmd_ctrl import tlb_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cmd_valid,
    input  tlb_op_t    cmd_op,
    input  tlb_idx_t   cmd_index,
    input  tlb_entry_t cmd_entry,
    input  asid_t      cmd_asid,
    input  vppn_t      cmd_vppn,
    input  logic       s_hit,
    input  tlb_idx_t   s_index,
    input  tlb_idx_t   fill_index,
    input  tlb_idx_t   sweep_index,
    input  logic       sweep_last,
    output vppn_t      s_vppn,
    output asid_t      s_asid,
    output logic       fill_step,
    output logic       sweep_start,
    output logic       sweep_step,
    output logic       rsp_valid,
    output logic       rsp_credit,
    output logic       rsp_hit,
    output tlb_idx_t   rsp_index,
    output tlb_entry_t rsp_entry,
    output logic       cmd_overflow,
    tlb_entry_if.ctrl  entry_if
);

    typedef struct packed {
        tlb_op_t    op;
        tlb_idx_t   index;
        tlb_entry_t entry;
        asid_t      asid;
        vppn_t      vppn;
    } cmd_t;

    cmd_t                 queue [cmd_depth];
    cmd_t                 cur;
    logic [cmd_ptr_w-1:0] wr_ptr;
    logic [cmd_ptr_w-1:0] rd_ptr;
    logic [cmd_ptr_w:0]   q_count;
    logic [cmd_ptr_w:0]   q_used;
    ctrl_state_t          state;
    logic                 push;
    logic                 pop;
    logic                 is_inv;
    logic                 clr_hit;

    // The command in progress holds its slot until its response.
    assign q_used = q_count + (cmd_ptr_w + 1)'(state != st_idle);

    // A command that finds the queue full is dropped.
    assign push = cmd_valid && (q_used < (cmd_ptr_w + 1)'(cmd_depth));
    assign pop  = (state == st_idle) && (q_count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= '{cmd_op, cmd_index, cmd_entry, cmd_asid, cmd_vppn};
        end
        if (pop) begin
            cur <= queue[rd_ptr];
        end
        if (state == st_exec) begin
            rsp_hit   <= (cur.op == op_srch) && s_hit;
            rsp_index <= (cur.op == op_srch) ? s_index : entry_if.w_index;
            rsp_entry <= entry_if.we ? cur.entry : entry_if.r_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            q_count      <= '0;
            cmd_overflow <= 1'b0;
            state        <= st_idle;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            q_count <= q_count + (cmd_ptr_w + 1)'(push) - (cmd_ptr_w + 1)'(pop);
            if (cmd_valid && !push) begin
                cmd_overflow <= 1'b1;
            end
            case (state)
                st_idle:  state <= pop ? st_exec : st_idle;
                st_exec:  state <= is_inv ? st_sweep : st_resp;
                st_sweep: state <= sweep_last ? st_resp : st_sweep;
                default:  state <= st_idle;
            endcase
        end
    end

    assign is_inv = (cur.op == op_inv_all) || (cur.op == op_inv_asid) || (cur.op == op_inv_va);

    assign s_vppn      = cur.vppn;
    assign s_asid      = cur.asid;
    assign fill_step   = (state == st_exec) && (cur.op == op_fill);
    assign sweep_start = (state == st_exec) && is_inv;
    assign sweep_step  = (state == st_sweep);

    assign entry_if.we      = (state == st_exec) && ((cur.op == op_wr) || fill_step);
    assign entry_if.w_index = (cur.op == op_fill) ? fill_index : cur.index;
    assign entry_if.w_entry = cur.entry;
    assign entry_if.r_index = sweep_step ? sweep_index :
                              (cur.op == op_srch) ? s_index : cur.index;

    // Clear rule for the entry under the sweep.
    always_comb begin
        case (cur.op)
            op_inv_all:  clr_hit = 1'b1;
            op_inv_asid: clr_hit = !entry_if.r_entry.g && (entry_if.r_entry.asid == cur.asid);
            op_inv_va:   clr_hit = entry_hit(entry_if.r_entry, cur.asid, cur.vppn, 1'b0);
            default:     clr_hit = 1'b0;
        endcase
    end

    assign entry_if.clr       = sweep_step && clr_hit;
    assign entry_if.clr_index = sweep_index;

    assign rsp_valid  = (state == st_resp);
    assign rsp_credit = (state == st_resp);

endmodule

/* hdl/tlb_top.sv */
module tlb_top import tlb_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // Command port.
    input  logic       cmd_valid,
    input  tlb_op_t    cmd_op,
    input  tlb_idx_t   cmd_index,
    input  tlb_entry_t cmd_entry,
    input  asid_t      cmd_asid,
    input  vppn_t      cmd_vppn,
    output logic       rsp_valid,
    output logic       rsp_credit,
    output logic       rsp_hit,
    output tlb_idx_t   rsp_index,
    output tlb_entry_t rsp_entry,
    output logic       cmd_overflow,
    // Fetch port.
    input  vppn_t      if_vppn,
    input  asid_t      if_asid,
    input  va_bits_t   if_va_bits,
    output ppn_t       if_ppn,
    output logic       if_v,
    output logic       if_d,
    output mat_t       if_mat,
    output plv_t       if_plv,
    output logic       if_miss,
    // Data port.
    input  vppn_t      dm_vppn,
    input  asid_t      dm_asid,
    input  va_bits_t   dm_va_bits,
    output ppn_t       dm_ppn,
    output logic       dm_v,
    output logic       dm_d,
    output mat_t       dm_mat,
    output plv_t       dm_plv,
    output logic       dm_miss
);

    tlb_entry_t         all_entries [tlb_num];
    logic [tlb_num-1:0] found_if;
    logic [tlb_num-1:0] found_dm;
    vppn_t              s_vppn;
    asid_t              s_asid;
    logic               s_hit;
    tlb_idx_t           s_index;
    logic               fill_step;
    logic               sweep_start;
    logic               sweep_step;
    tlb_idx_t           fill_index;
    tlb_idx_t           sweep_index;
    logic               sweep_last;

    tlb_entry_if entry_if ();

    tlb_entry_array tlb_entry_array_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .entry_if    (entry_if.array),
        .all_entries (all_entries)
    );

    tlb_match tlb_match_inst (
        .all_entries (all_entries),
        .s0_vppn     (if_vppn),
        .s0_asid     (if_asid),
        .s1_vppn     (dm_vppn),
        .s1_asid     (dm_asid),
        .s_vppn      (s_vppn),
        .s_asid      (s_asid),
        .found0      (found_if),
        .found1      (found_dm),
        .s_hit       (s_hit),
        .s_index     (s_index)
    );

    tlb_translate tlb_translate_if_inst (
        .all_entries (all_entries),
        .found       (found_if),
        .va_bits     (if_va_bits),
        .pa_ppn      (if_ppn),
        .pa_v        (if_v),
        .pa_d        (if_d),
        .pa_mat      (if_mat),
        .pa_plv      (if_plv),
        .miss        (if_miss)
    );

    tlb_translate tlb_translate_dm_inst (
        .all_entries (all_entries),
        .found       (found_dm),
        .va_bits     (dm_va_bits),
        .pa_ppn      (dm_ppn),
        .pa_v        (dm_v),
        .pa_d        (dm_d),
        .pa_mat      (dm_mat),
        .pa_plv      (dm_plv),
        .miss        (dm_miss)
    );

    tlb_index_counter tlb_index_counter_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fill_step   (fill_step),
        .sweep_start (sweep_start),
        .sweep_step  (sweep_step),
        .fill_index  (fill_index),
        .sweep_index (sweep_index),
        .sweep_last  (sweep_last)
    );

    tlb_cmd_ctrl tlb_cmd_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_index    (cmd_index),
        .cmd_entry    (cmd_entry),
        .cmd_asid     (cmd_asid),
        .cmd_vppn     (cmd_vppn),
        .s_hit        (s_hit),
        .s_index      (s_index),
        .fill_index   (fill_index),
        .sweep_index  (sweep_index),
        .sweep_last   (sweep_last),
        .s_vppn       (s_vppn),
        .s_asid       (s_asid),
        .fill_step    (fill_step),
        .sweep_start  (sweep_start),
        .sweep_step   (sweep_step),
        .rsp_valid    (rsp_valid),
        .rsp_credit   (rsp_credit),
        .rsp_hit      (rsp_hit),
        .rsp_index    (rsp_index),
        .rsp_entry    (rsp_entry),
        .cmd_overflow (cmd_overflow),
        .entry_if     (entry_if.ctrl)
    );

endmodule

/* verification/tlb_checker.sv */
module tlb_checker import tlb_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rsp_valid,
    input  logic       rsp_credit,
    input  logic       rsp_hit,
    input  tlb_idx_t   rsp_index,
    input  tlb_entry_t rsp_entry,
    input  logic       cmd_overflow,
    input  page_attr_t if_page,
    input  logic       if_miss,
    input  page_attr_t dm_page,
    input  logic       dm_miss
);

    int         q_id [$];
    tlb_op_t    q_op [$];
    logic       q_hit [$];
    tlb_idx_t   q_idx [$];
    tlb_entry_t q_ent [$];
    int         n_pass = 0;
    int         n_fail = 0;
    int         errors = 0;

    function automatic bit check_value(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic int pending();
        return q_id.size();
    endfunction

    function automatic bit failed();
        return (errors != 0) || (n_fail != 0);
    endfunction

    task automatic report_test(int id, string what, bit ok);
        if (ok) begin
            n_pass++;
            $display("test %0d %s passed", id, what);
        end else begin
            n_fail++;
            $display("test %0d %s FAILED", id, what);
        end
    endtask

    task automatic expect_rsp(int id, tlb_op_t op, logic hit, tlb_idx_t idx, tlb_entry_t ent);
        q_id.push_back(id);
        q_op.push_back(op);
        q_hit.push_back(hit);
        q_idx.push_back(idx);
        q_ent.push_back(ent);
    endtask

    task automatic check_lookup(int id, logic e_if_miss, page_attr_t e_if, logic e_dm_miss,
                                page_attr_t e_dm);
        bit ok;
        ok = 1'b1;
        ok = check_value("if_miss", if_miss, e_if_miss) && ok;
        ok = check_value("if_page", if_page, e_if) && ok;
        ok = check_value("dm_miss", dm_miss, e_dm_miss) && ok;
        ok = check_value("dm_page", dm_page, e_dm) && ok;
        report_test(id, "lookup", ok);
    endtask

    task automatic check_overflow(int id, logic exp);
        report_test(id, "overflow flag", check_value("cmd_overflow", cmd_overflow, exp));
    endtask

    task automatic print_counts();
        $display("tests passed %0d, tests failed %0d, errors %0d", n_pass, n_fail, errors);
    endtask

    always @(posedge clk) begin : watch_rsp
        bit       ok;
        int       id;
        tlb_op_t  op;
        if (rst_n) begin
            if (rsp_valid !== rsp_credit) begin
                $display("ERROR at %0t: credit pulse does not match the response", $time);
                errors++;
            end
            if (rsp_valid === 1'b1) begin
                if (q_id.size() == 0) begin
                    $display("ERROR at %0t: response with no command outstanding", $time);
                    errors++;
                end else begin
                    id = q_id.pop_front();
                    op = q_op.pop_front();
                    ok = 1'b1;
                    ok = check_value("rsp_hit", rsp_hit, q_hit.pop_front()) && ok;
                    ok = check_value("rsp_index", rsp_index, q_idx.pop_front()) && ok;
                    // Only read, write and fill return a defined entry.
                    if (op == op_rd || op == op_wr || op == op_fill) begin
                        ok = check_value("rsp_entry", rsp_entry, q_ent.pop_front()) && ok;
                    end else begin
                        void'(q_ent.pop_front());
                    end
                    report_test(id, $sformatf("command op %0d", op), ok);
                end
            end
        end
    end

endmodule

/* verification/tlb_tb.sv */
module tlb_tb import tlb_pkg::*; ();

    typedef struct packed {
        int         kind;
        tlb_op_t    op;
        bit         burst;
        bit         drop;
        tlb_idx_t   idx;
        tlb_entry_t ent;
        asid_t      asid;
        vppn_t      vppn;
        va_bits_t   va;
        asid_t      dm_asid_r;
        vppn_t      dm_vppn_r;
        va_bits_t   dm_va_r;
        logic       exp_hit;
        tlb_idx_t   exp_idx;
        logic       e_if_miss;
        page_attr_t e_if;
        logic       e_dm_miss;
        page_attr_t e_dm;
    } row_t;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic cmd_valid, rsp_valid, rsp_credit, rsp_hit, cmd_overflow;
    tlb_op_t cmd_op;
    tlb_idx_t cmd_index, rsp_index;
    tlb_entry_t cmd_entry, rsp_entry;
    asid_t cmd_asid, if_asid, dm_asid;
    vppn_t cmd_vppn, if_vppn, dm_vppn;
    va_bits_t if_va_bits, dm_va_bits;
    ppn_t if_ppn, dm_ppn;
    logic if_v, if_d, if_miss, dm_v, dm_d, dm_miss;
    mat_t if_mat, dm_mat;
    plv_t if_plv, dm_plv;
    page_attr_t if_page, dm_page;
    row_t rows [$];
    int credits = cmd_depth;
    int cycles = 0;
    int limit = 0;

    assign if_page = {if_ppn, if_v, if_d, if_mat, if_plv};
    assign dm_page = {dm_ppn, dm_v, dm_d, dm_mat, dm_plv};

    tlb_top tlb_top_inst (.*);

    tlb_checker tlb_checker_inst (
        .clk (clk), .rst_n (rst_n), .rsp_valid (rsp_valid), .rsp_credit (rsp_credit),
        .rsp_hit (rsp_hit), .rsp_index (rsp_index), .rsp_entry (rsp_entry),
        .cmd_overflow (cmd_overflow), .if_page (if_page), .if_miss (if_miss),
        .dm_page (dm_page), .dm_miss (dm_miss)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rsp_credit === 1'b1) begin
            credits++;
        end
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the run went past %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic page_attr_t mk_page(ppn_t ppn, logic v, logic d, mat_t mat, plv_t plv);
        return '{ppn, v, d, mat, plv};
    endfunction

    function automatic tlb_entry_t mk_entry(logic g, ps_t ps, asid_t asid, vppn_t vppn,
                                            page_attr_t p0, page_attr_t p1);
        return '{1'b1, g, ps, asid, vppn, p0, p1};
    endfunction

    task automatic add_cmd(tlb_op_t op, tlb_idx_t idx, tlb_entry_t ent, asid_t asid, vppn_t vppn,
                           logic hit, tlb_idx_t eidx, bit burst = 0, bit drop = 0);
        row_t r;
        r = '{default: '0};
        r.kind = 0;
        r.op = op;
        r.idx = idx;
        r.ent = ent;
        r.asid = asid;
        r.vppn = vppn;
        r.exp_hit = hit;
        r.exp_idx = eidx;
        r.burst = burst;
        r.drop = drop;
        rows.push_back(r);
    endtask

    task automatic add_look(asid_t a0, vppn_t v0, va_bits_t va0, asid_t a1, vppn_t v1,
                            va_bits_t va1, logic m0, page_attr_t p0, logic m1, page_attr_t p1);
        row_t r;
        r = '{default: '0};
        r.kind = 1;
        r.asid = a0;
        r.vppn = v0;
        r.va = va0;
        r.dm_asid_r = a1;
        r.dm_vppn_r = v1;
        r.dm_va_r = va1;
        r.e_if_miss = m0;
        r.e_if = p0;
        r.e_dm_miss = m1;
        r.e_dm = p1;
        rows.push_back(r);
    endtask

    task automatic add_ovf(logic exp);
        row_t r;
        r = '{default: '0};
        r.kind = 2;
        r.exp_hit = exp;
        rows.push_back(r);
    endtask

    task automatic build_table();
        tlb_entry_t ea, eb, eg, ef, ec, ed;
        ea = mk_entry(0, ps_4k, 10'd1, 19'h12345, mk_page(20'h11111, 1, 0, 1, 0),
                      mk_page(20'h22222, 1, 1, 2, 3));
        eb = mk_entry(0, ps_4m, 10'd2, 19'h40000, mk_page(20'hABC00, 1, 0, 1, 1),
                      mk_page(20'hDEF00, 1, 1, 0, 1));
        eg = mk_entry(1, ps_4k, 10'd7, 19'h00777, mk_page(20'h33333, 1, 0, 0, 0),
                      mk_page(20'h44444, 0, 1, 3, 2));
        // Random ASID with bit 9 set never equals an ASID the tests use.
        ef = mk_entry(0, ps_4k, asid_t'($urandom()) | 10'h200, 19'h7FFF0,
                      mk_page(20'h55555, 1, 1, 1, 1), mk_page(20'h66666, 1, 1, 1, 1));
        ec = mk_entry(0, ps_4k, 10'd4, 19'h00100, mk_page(20'h77777, 1, 0, 0, 1), '0);
        ed = mk_entry(0, ps_4k, 10'd4, 19'h00200, mk_page(20'h88888, 1, 1, 0, 1), '0);
        add_cmd(op_wr, 5, ea, 0, 0, 0, 5);
        add_cmd(op_wr, 9, eb, 0, 0, 0, 9);
        add_cmd(op_wr, 17, eg, 0, 0, 0, 17);
        add_cmd(op_wr, 30, ef, 0, 0, 0, 30);
        add_cmd(op_rd, 5, ea, 0, 0, 0, 5);
        add_cmd(op_rd, 9, eb, 0, 0, 0, 9);
        add_cmd(op_srch, 0, '0, 1, 19'h12345, 1, 5);
        add_cmd(op_srch, 0, '0, 2, 19'h40000, 1, 9);
        add_cmd(op_srch, 0, '0, 2, 19'h40012, 0, 0);
        add_cmd(op_srch, 0, '0, 3, 19'h00777, 1, 17);
        add_look(1, 19'h12345, 10'h000, 1, 19'h12345, 10'h001,
                 0, mk_page(20'h11111, 1, 0, 1, 0), 0, mk_page(20'h22222, 1, 1, 2, 3));
        add_look(2, 19'h400AB, 10'h205, 1, 19'h12300, 10'h000,
                 0, mk_page(20'hDEE05, 1, 1, 0, 1), 1, '0);
        add_look(5, 19'h12345, 10'h000, 5, 19'h00777, 10'h001,
                 1, '0, 0, mk_page(20'h44444, 0, 1, 3, 2));
        add_cmd(op_fill, 0, ec, 0, 0, 0, 0);
        add_cmd(op_fill, 0, ed, 0, 0, 0, 1);
        add_cmd(op_rd, 0, ec, 0, 0, 0, 0);
        add_cmd(op_rd, 1, ed, 0, 0, 0, 1);
        add_cmd(op_inv_asid, 0, '0, 4, 0, 0, 0);
        add_cmd(op_srch, 0, '0, 4, 19'h00100, 0, 0);
        add_cmd(op_inv_va, 0, '0, 2, 19'h400FF, 0, 0);
        add_cmd(op_srch, 0, '0, 2, 19'h40000, 0, 0);
        add_cmd(op_srch, 0, '0, 1, 19'h12345, 1, 5);
        add_look(2, 19'h40000, 10'h000, 9, 19'h00777, 10'h000,
                 1, '0, 0, mk_page(20'h33333, 1, 0, 0, 0));
        add_cmd(op_inv_all, 0, '0, 0, 0, 0, 0);
        add_cmd(op_srch, 0, '0, 3, 19'h00777, 0, 0);
        add_look(1, 19'h12345, 10'h000, 9, 19'h00777, 10'h000, 1, '0, 1, '0);
        add_ovf(0);
        // The third command goes out with no credit left and is dropped.
        add_cmd(op_inv_all, 0, '0, 0, 0, 0, 0, 1);
        add_cmd(op_srch, 0, '0, 1, 19'h12345, 0, 0, 1);
        add_cmd(op_srch, 0, '0, 3, 19'h00777, 0, 0, 1, 1);
        add_ovf(1);
    endtask

    task automatic wait_idle();
        while (tlb_checker_inst.pending() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_cmd(int id, row_t r);
        cmd_op = r.op;
        cmd_index = r.idx;
        cmd_entry = r.ent;
        cmd_asid = r.asid;
        cmd_vppn = r.vppn;
        cmd_valid = 1'b1;
        if (!r.drop) begin
            credits--;
            tlb_checker_inst.expect_rsp(id, r.op, r.exp_hit, r.exp_idx, r.ent);
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(85));
        cmd_valid = 1'b0;
        cmd_op = op_srch;
        cmd_index = '0;
        cmd_entry = '0;
        cmd_asid = '0;
        cmd_vppn = '0;
        if_asid = '0;
        if_vppn = '0;
        if_va_bits = '0;
        dm_asid = '0;
        dm_vppn = '0;
        dm_va_bits = '0;
        build_table();
        limit = rows.size() * 40 + 100;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (rows[i]) begin
            if (rows[i].kind == 0) begin
                while (!rows[i].burst && credits == 0) begin
                    @(posedge clk);
                    #1;
                end
                send_cmd(i + 1, rows[i]);
            end else if (rows[i].kind == 1) begin
                wait_idle();
                if_asid = rows[i].asid;
                if_vppn = rows[i].vppn;
                if_va_bits = rows[i].va;
                dm_asid = rows[i].dm_asid_r;
                dm_vppn = rows[i].dm_vppn_r;
                dm_va_bits = rows[i].dm_va_r;
                #2;
                tlb_checker_inst.check_lookup(i + 1, rows[i].e_if_miss, rows[i].e_if,
                                              rows[i].e_dm_miss, rows[i].e_dm);
                @(posedge clk);
                #1;
            end else begin
                wait_idle();
                // A stray response would show up in this quiet time.
                repeat (10) @(posedge clk);
                #1;
                tlb_checker_inst.check_overflow(i + 1, rows[i].exp_hit);
            end
        end
        wait_idle();
        tlb_checker_inst.print_counts();
        if (tlb_checker_inst.failed()) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/tlb_pkg.sv
hdl/tlb_entry_if.sv
hdl/tlb_entry_array.sv
hdl/tlb_match.sv
hdl/tlb_translate.sv
hdl/tlb_index_counter.sv
hdl/tlb_cmd_ctrl.sv
hdl/tlb_top.sv
verification/tlb_checker.sv
verification/tlb_tb.sv

/* Bender.yml */
package:
  name: tlb

sources:
  - hdl/tlb_pkg.sv
  - hdl/tlb_entry_if.sv
  - hdl/tlb_entry_array.sv
  - hdl/tlb_match.sv
  - hdl/tlb_translate.sv
  - hdl/tlb_index_counter.sv
  - hdl/tlb_cmd_ctrl.sv
  - hdl/tlb_top.sv
  - target: test
    files:
      - verification/tlb_checker.sv
      - verification/tlb_tb.sv
